// ==== common/centipede_io_config.svh ====
// -----------------------------
// bus, trackball counter and
// synchronizer width defines for
// the centipede i/o board
// -----------------------------

`ifndef CENTIPEDE_IO_CONFIG_SVH
`define CENTIPEDE_IO_CONFIG_SVH

// cpu address bus as seen by the i/o board
// bits 13 to 10 select the region
`define CIO_ADDR_W 14

// cpu data bus
`define CIO_DATA_W 8

// mini-trackball up/down counter, one nibble per axis
`define CIO_TB_CTR_W 4

// flops between the trackball pins and the s_6mhz domain
// two is the minimum for metastability
`define CIO_SYNC_STAGES 2

`endif

// ==== common/centipede_io_pkg.sv ====
// -----------------------------
// bus types, region opcodes and
// trackball direction type
// -----------------------------

`include "centipede_io_config.svh"

package centipede_io_pkg;

   // cpu address, only the low 14 bits reach the i/o board
   typedef logic [`CIO_ADDR_W-1:0] cio_addr_t;

   // one byte on the cpu data bus
   typedef logic [`CIO_DATA_W-1:0] cio_data_t;

   // one trackball axis count
   typedef logic [`CIO_TB_CTR_W-1:0] tb_count_t;

   // i/o region opcode, same code as address bits 13..10
   // only the regions handled by this board get a name
   typedef enum logic [3:0]
   {
      // option switch banks sw1 / sw2
      REGION_SWITCH   = 4'd2,
      // player inputs, trackball counts, joystick
      REGION_INPUT    = 4'd3,
      // addressable output latch
      REGION_OUT0     = 4'd7,
      // clears both trackball counters
      REGION_STEERCLR = 4'd9,
      // rom, ram, playfield, pokey and the rest
      REGION_UNMAPPED = 4'd15
   } io_region_e;

   // direction latched on each trackball clock edge
   typedef enum logic
   {
      TB_DOWN = 1'b0,
      TB_UP   = 1'b1
   } tb_dir_e;

endpackage

// ==== logic/io_addr_decoder.sv ====
// -----------------------------
// address decoder for the i/o
// regions and the write strobes
// -----------------------------

`timescale 1ns/1ps

`include "centipede_io_config.svh"

module io_addr_decoder
   import centipede_io_pkg::*;
(
   input  logic       s_6mhz,
   input  logic       reset,
   input  cio_addr_t  addr_i,
   input  logic       rd_i,
   input  logic       wr_i,
   output io_region_e region_o,
   output logic       latch_we_o,
   output logic       steer_clr_o
);

   // region select field, top four address bits
   logic [3:0] region_bits;

   assign region_bits = addr_i[`CIO_ADDR_W-1 -: 4];

   // one-hot decode of the old 74ls42 reduced to the four live regions
   always_comb
   begin
      case (region_bits)
         4'd2:    region_o = REGION_SWITCH;
         4'd3:    region_o = REGION_INPUT;
         4'd7:    region_o = REGION_OUT0;
         4'd9:    region_o = REGION_STEERCLR;
         default: region_o = REGION_UNMAPPED;
      endcase
   end

   // write strobes, qualified by the bus write
   // reads of these regions are harmless and return zero
   assign latch_we_o  = wr_i && (region_o == REGION_OUT0);
   assign steer_clr_o = wr_i && (region_o == REGION_STEERCLR);

   // the 6502 drives only one direction per bus cycle
   a_rd_wr_excl : assert property (
      @(posedge s_6mhz) disable iff (reset)
      !(rd_i && wr_i)
   );

endmodule

// ==== logic/input_read_mux.sv ====
// -----------------------------
// cpu read data mux for switches,
// player inputs, joystick and
// trackball counts
// -----------------------------

`timescale 1ns/1ps

module input_read_mux
   import centipede_io_pkg::*;
(
   input  logic       s_6mhz,
   input  logic       reset,
   input  logic       rd_i,
   input  io_region_e region_i,
   input  cio_addr_t  addr_i,
   input  cio_data_t  sw1_i,
   input  cio_data_t  sw2_i,
   input  logic [9:0] player_i,
   input  cio_data_t  joystick_i,
   input  logic       vblank_i,
   input  tb_count_t  h_count_i,
   input  tb_count_t  v_count_i,
   input  tb_dir_e    h_dir_i,
   input  tb_dir_e    v_dir_i,
   output cio_data_t  rdata_o,
   output logic       rdata_valid_o
);

   // byte selected for the current address, before the register
   cio_data_t rd_byte;

   // in0 low byte: trackball h, vblank, self test, cocktail
   cio_data_t in0_lo;
   // in0 high byte: coins, slam, fire and start buttons
   cio_data_t in0_hi;
   // in1 low byte: trackball v with its direction
   cio_data_t in1_lo;

   assign in0_lo = {h_dir_i, vblank_i, player_i[6], player_i[5], h_count_i};

   // coin r/c/l, slam, fire2, fire1, start2, start1
   assign in0_hi = {player_i[9], player_i[8], player_i[7], player_i[4],
                    player_i[1], player_i[0], player_i[3], player_i[2]};

   assign in1_lo = {v_dir_i, 3'b000, v_count_i};

   always_comb
   begin
      case (region_i)
         // a0 picks the bank
         REGION_SWITCH:
            rd_byte = addr_i[0] ? sw2_i : sw1_i;
         // a1 picks in0 or in1, a0 the byte
         REGION_INPUT:
            case (addr_i[1:0])
               2'b00:   rd_byte = in0_lo;
               2'b01:   rd_byte = in0_hi;
               2'b10:   rd_byte = in1_lo;
               default: rd_byte = joystick_i;
            endcase
         // write-only regions and everything unmapped read as zero
         default:
            rd_byte = '0;
      endcase
   end

   // one cycle read latency, data holds until the next read
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         rdata_o       <= '0;
         rdata_valid_o <= 1'b0;
      end
      else
      begin
         rdata_valid_o <= rd_i;
         if (rd_i)
            rdata_o <= rd_byte;
      end
   end

   // valid only ever follows a read strobe by one cycle
   a_valid_after_rd : assert property (
      @(posedge s_6mhz) disable iff (reset)
      rdata_valid_o |-> $past(rd_i)
   );

endmodule

// ==== logic/output_latch.sv ====
// -----------------------------
// eight bit addressable latch for
// flip, leds and coin counters
// -----------------------------

`timescale 1ns/1ps

module output_latch
   import centipede_io_pkg::*;
(
   input  logic       s_6mhz,
   input  logic       reset,
   input  logic       we_i,
   input  logic [2:0] bit_sel_i,
   input  logic       bit_i,
   output logic       flip_o,
   output logic [4:1] led_o,
   output logic [2:0] coin_ctr_o
);

   // 9334-style latch, one bit written per cpu store
   cio_data_t latch_q;

   // only the addressed bit changes, the rest hold
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         latch_q <= '0;
      end
      else if (we_i)
      begin
         latch_q[bit_sel_i] <= bit_i;
      end
   end

   // bit 7 flips the screen for cocktail play
   // and swaps the trackball player
   assign flip_o = latch_q[7];

   // start button lamps
   assign led_o[4] = latch_q[6];
   assign led_o[3] = latch_q[5];
   assign led_o[2] = latch_q[4];
   assign led_o[1] = latch_q[3];

   // coin counter drives: right, center, left
   assign coin_ctr_o = latch_q[2:0];

endmodule

// ==== trackball/trackball_axis.sv ====
// -----------------------------
// one mini-trackball axis with
// player select, synchronizer and
// up/down counter
// -----------------------------

`timescale 1ns/1ps

`include "centipede_io_config.svh"

module trackball_axis
   import centipede_io_pkg::*;
(
   input  logic      s_6mhz,
   input  logic      reset,
   input  logic      flip_i,
   input  logic      p1_clk_i,
   input  logic      p1_dir_i,
   input  logic      p2_clk_i,
   input  logic      p2_dir_i,
   input  logic      clear_i,
   output tb_count_t count_o,
   output tb_dir_e   dir_o
);

   localparam int SYNC_MSB = `CIO_SYNC_STAGES - 1;

   // selected player's raw trackball lines
   logic clk_sel;
   logic dir_sel;

   // synchronizer chains, bit 0 is the first flop
   logic [SYNC_MSB:0] clk_sync;
   logic [SYNC_MSB:0] dir_sync;

   // previous synchronized clock for the edge detect
   logic clk_prev;
   logic clk_rise;

   tb_dir_e   dir_q;
   tb_count_t count_q;

   // cocktail: flip high hands the trackball to player 1
   assign clk_sel = flip_i ? p1_clk_i : p2_clk_i;
   assign dir_sel = flip_i ? p1_dir_i : p2_dir_i;

   // clock and direction share the same depth so they stay aligned
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         clk_sync <= '0;
         dir_sync <= '0;
         clk_prev <= 1'b0;
      end
      else
      begin
         clk_sync <= {clk_sync[SYNC_MSB-1:0], clk_sel};
         dir_sync <= {dir_sync[SYNC_MSB-1:0], dir_sel};
         clk_prev <= clk_sync[SYNC_MSB];
      end
   end

   assign clk_rise = clk_sync[SYNC_MSB] && !clk_prev;

   // direction is captured on the edge and used for that same step
   // steering clear wins over a count in the same cycle
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         dir_q   <= TB_DOWN;
         count_q <= '0;
      end
      else
      begin
         if (clk_rise)
            dir_q <= tb_dir_e'(dir_sync[SYNC_MSB]);
         if (clear_i)
            count_q <= '0;
         else if (clk_rise)
            count_q <= dir_sync[SYNC_MSB] ? count_q + tb_count_t'(1)
                                          : count_q - tb_count_t'(1);
      end
   end

   assign count_o = count_q;
   assign dir_o   = dir_q;

   // the count only moves on a trackball edge or a steering clear
   a_count_stable : assert property (
      @(posedge s_6mhz) disable iff (reset)
      (!clk_rise && !clear_i) |=> $stable(count_q)
   );

endmodule

// ==== logic/centipede_io_top.sv ====
// -----------------------------
// centipede i/o board top level,
// decoder, read mux, output latch
// and two trackball axes
// -----------------------------

`timescale 1ns/1ps

module centipede_io_top
   import centipede_io_pkg::*;
(
   input  logic       s_6mhz,
   input  logic       reset,
   // cpu bus
   input  cio_addr_t  addr_i,
   input  cio_data_t  wdata_i,
   input  logic       rd_i,
   input  logic       wr_i,
   // cabinet inputs
   input  cio_data_t  sw1_i,
   input  cio_data_t  sw2_i,
   input  logic [9:0] player_i,
   input  cio_data_t  joystick_i,
   input  logic [7:0] trakball_i,
   input  logic       vblank_i,
   // read return
   output cio_data_t  rdata_o,
   output logic       rdata_valid_o,
   // cabinet outputs
   output logic       flip_o,
   output logic [4:1] led_o,
   output logic [2:0] coin_ctr_o
);

   io_region_e region;
   logic       latch_we;
   logic       steer_clr;

   // trackball results into the read mux
   tb_count_t  h_count;
   tb_count_t  v_count;
   tb_dir_e    h_dir;
   tb_dir_e    v_dir;

   io_addr_decoder u_decoder (
      .s_6mhz      (s_6mhz),
      .reset       (reset),
      .addr_i      (addr_i),
      .rd_i        (rd_i),
      .wr_i        (wr_i),
      .region_o    (region),
      .latch_we_o  (latch_we),
      .steer_clr_o (steer_clr)
   );

   input_read_mux u_read_mux (
      .s_6mhz        (s_6mhz),
      .reset         (reset),
      .rd_i          (rd_i),
      .region_i      (region),
      .addr_i        (addr_i),
      .sw1_i         (sw1_i),
      .sw2_i         (sw2_i),
      .player_i      (player_i),
      .joystick_i    (joystick_i),
      .vblank_i      (vblank_i),
      .h_count_i     (h_count),
      .v_count_i     (v_count),
      .h_dir_i       (h_dir),
      .v_dir_i       (v_dir),
      .rdata_o       (rdata_o),
      .rdata_valid_o (rdata_valid_o)
   );

   // a2..a0 address the latch bit, d7 is the value
   output_latch u_latch (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .we_i       (latch_we),
      .bit_sel_i  (addr_i[2:0]),
      .bit_i      (wdata_i[7]),
      .flip_o     (flip_o),
      .led_o      (led_o),
      .coin_ctr_o (coin_ctr_o)
   );

   // horizontal: dir on 7/6, clock on 5/4 for player 1/2
   trackball_axis axis_h (
      .s_6mhz   (s_6mhz),
      .reset    (reset),
      .flip_i   (flip_o),
      .p1_clk_i (trakball_i[5]),
      .p1_dir_i (trakball_i[7]),
      .p2_clk_i (trakball_i[4]),
      .p2_dir_i (trakball_i[6]),
      .clear_i  (steer_clr),
      .count_o  (h_count),
      .dir_o    (h_dir)
   );

   // vertical: dir on 3/2, clock on 1/0 for player 1/2
   trackball_axis axis_v (
      .s_6mhz   (s_6mhz),
      .reset    (reset),
      .flip_i   (flip_o),
      .p1_clk_i (trakball_i[1]),
      .p1_dir_i (trakball_i[3]),
      .p2_clk_i (trakball_i[0]),
      .p2_dir_i (trakball_i[2]),
      .clear_i  (steer_clr),
      .count_o  (v_count),
      .dir_o    (v_dir)
   );

endmodule

// ==== sim/tb_centipede_io.sv ====
// -----------------------------
// directed testbench for the i/o
// board: clock, reset, watchdog,
// compare tasks and test tasks
// -----------------------------

`timescale 1ns/1ps

module tb_centipede_io
   import centipede_io_pkg::*;
();

   // region codes on address bits 13..10
   localparam logic [3:0] CODE_SWITCH   = 4'd2;
   localparam logic [3:0] CODE_INPUT    = 4'd3;
   localparam logic [3:0] CODE_OUT0     = 4'd7;
   localparam logic [3:0] CODE_STEERCLR = 4'd9;

   // trakball_i pin groups, h and v together
   localparam logic [7:0] P1_CLK  = 8'b0010_0010;
   localparam logic [7:0] P2_CLK  = 8'b0001_0001;
   localparam logic [7:0] P1_HDIR = 8'h80;
   localparam logic [7:0] P1_VDIR = 8'h08;
   localparam logic [7:0] P2_HDIR = 8'h40;
   localparam logic [7:0] P2_VDIR = 8'h04;

   // cycles each trackball clock level is held
   localparam int CLK_HOLD     = 6;
   localparam int READ_TIMEOUT = 16;
   // about 40 trackball pulses of 13 cycles and 150 bus cycles of 4,
   // roughly 1200 cycles in all, so 20000 is ample
   localparam int WATCHDOG_CYCLES = 20000;

   logic       s_6mhz;
   logic       reset;
   cio_addr_t  addr;
   cio_data_t  wdata;
   logic       rd;
   logic       wr;
   cio_data_t  sw1;
   cio_data_t  sw2;
   logic [9:0] player;
   cio_data_t  joystick;
   logic [7:0] trakball;
   logic       vblank;
   cio_data_t  rdata;
   logic       rdata_valid;
   logic       flip;
   logic [4:1] led;
   logic [2:0] coin_ctr;

   integer     seed;

   // reference state: latch contents and trackball axes
   logic [7:0] exp_latch;
   tb_count_t  exp_h_count;
   tb_count_t  exp_v_count;
   logic       exp_h_dir;
   logic       exp_v_dir;

   centipede_io_top DUT (
      .s_6mhz        (s_6mhz),
      .reset         (reset),
      .addr_i        (addr),
      .wdata_i       (wdata),
      .rd_i          (rd),
      .wr_i          (wr),
      .sw1_i         (sw1),
      .sw2_i         (sw2),
      .player_i      (player),
      .joystick_i    (joystick),
      .trakball_i    (trakball),
      .vblank_i      (vblank),
      .rdata_o       (rdata),
      .rdata_valid_o (rdata_valid),
      .flip_o        (flip),
      .led_o         (led),
      .coin_ctr_o    (coin_ctr)
   );

   initial
   begin
      s_6mhz = 1'b0;
      forever #5 s_6mhz = ~s_6mhz;
   end

   // prints the reason, then stops the run
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Testbench failed");
      $fatal(1, "run stopped at the first error");
   endtask

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge s_6mhz);
      abort_run($sformatf("watchdog expired after %0d cycles, a test hung", WATCHDOG_CYCLES));
   end

   task automatic compare_data(input string name, input cio_data_t act, input cio_data_t exp);
      if (act !== exp)
         abort_run($sformatf("** Error at time %0t: %s = %02h, expected %02h",
                             $time, name, act, exp));
   endtask

   task automatic compare_count(input string name, input tb_count_t act, input tb_count_t exp);
      if (act !== exp)
         abort_run($sformatf("** Error at time %0t: %s = %0d, expected %0d",
                             $time, name, act, exp));
   endtask

   task automatic compare_bit(input string name, input logic act, input logic exp);
      if (act !== exp)
         abort_run($sformatf("** Error at time %0t: %s = %b, expected %b",
                             $time, name, act, exp));
   endtask

   function automatic cio_addr_t make_addr(input logic [3:0] code, input logic [9:0] offset);
      return {code, offset};
   endfunction

   // one write cycle, strobe high for a single clock
   task automatic bus_write(input cio_addr_t a, input cio_data_t d);
      @(negedge s_6mhz);
      addr  = a;
      wdata = d;
      wr    = 1'b1;
      @(negedge s_6mhz);
      wr = 1'b0;
   endtask

   // read strobe for one clock, then wait for the valid pulse
   task automatic bus_read(input cio_addr_t a, output cio_data_t d);
      int waited;
      @(negedge s_6mhz);
      addr = a;
      rd   = 1'b1;
      @(negedge s_6mhz);
      rd     = 1'b0;
      waited = 0;
      while (!rdata_valid && waited < READ_TIMEOUT)
      begin
         @(negedge s_6mhz);
         waited++;
      end
      if (!rdata_valid)
         abort_run($sformatf("read of address %h never raised rdata_valid_o", a));
      if (waited != 0)
         abort_run($sformatf("read of address %h took %0d extra cycles", a, waited));
      d = rdata;
      // valid is a single-cycle pulse
      @(negedge s_6mhz);
      compare_bit("rdata_valid_o", rdata_valid, 1'b0);
   endtask

   task automatic check_latch_outputs();
      compare_bit("flip_o", flip, exp_latch[7]);
      for (int i = 1; i <= 4; i++)
         compare_bit($sformatf("led_o[%0d]", i), led[i], exp_latch[i + 2]);
      for (int i = 0; i <= 2; i++)
         compare_bit($sformatf("coin_ctr_o[%0d]", i), coin_ctr[i], exp_latch[i]);
   endtask

   // reads in0 low and in1 low and checks both axes
   task automatic check_trackball();
      cio_data_t  d;
      logic [9:0] rnd;
      rnd = $random(seed);
      bus_read(make_addr(CODE_INPUT, {rnd[9:2], 2'b00}), d);
      compare_count("rdata_o[3:0] h count", d[3:0], exp_h_count);
      compare_bit("rdata_o[7] h dir", d[7], exp_h_dir);
      bus_read(make_addr(CODE_INPUT, {rnd[9:2], 2'b10}), d);
      compare_count("rdata_o[3:0] v count", d[3:0], exp_v_count);
      compare_bit("rdata_o[7] v dir", d[7], exp_v_dir);
      compare_data("rdata_o[6:4] in1 zeros", d & 8'h70, 8'h00);
   endtask

   // one clock pulse on a player's h and v lines, direction set while low
   task automatic pulse_trackball(input logic p1_lines, input logic up_h, input logic up_v);
      logic [7:0] clk_mask;
      logic [7:0] dir_mask;
      logic [7:0] dir_set;
      clk_mask = p1_lines ? P1_CLK : P2_CLK;
      dir_mask = p1_lines ? (P1_HDIR | P1_VDIR) : (P2_HDIR | P2_VDIR);
      dir_set  = ((p1_lines ? P1_HDIR : P2_HDIR) & {8{up_h}})
               | ((p1_lines ? P1_VDIR : P2_VDIR) & {8{up_v}});
      @(negedge s_6mhz);
      trakball = (trakball & ~dir_mask) | dir_set;
      repeat (CLK_HOLD) @(negedge s_6mhz);
      trakball = trakball | clk_mask;
      repeat (CLK_HOLD) @(negedge s_6mhz);
      trakball = trakball & ~clk_mask;
      // flip high picks player 1, the other player is ignored
      if (p1_lines == exp_latch[7])
      begin
         exp_h_count = up_h ? exp_h_count + 4'd1 : exp_h_count - 4'd1;
         exp_v_count = up_v ? exp_v_count + 4'd1 : exp_v_count - 4'd1;
         exp_h_dir   = up_h;
         exp_v_dir   = up_v;
      end
   endtask

   task automatic verify_reset_state();
      cio_data_t d;
      check_latch_outputs();
      compare_bit("rdata_valid_o", rdata_valid, 1'b0);
      compare_data("rdata_o", rdata, 8'h00);
      @(negedge s_6mhz);
      player = $random(seed);
      vblank = $random(seed);
      // counts and directions are still zero
      bus_read(make_addr(CODE_INPUT, 10'h000), d);
      compare_data("rdata_o in0 low", d, {1'b0, vblank, player[6], player[5], 4'h0});
   endtask

   task automatic sweep_switches_and_unmapped();
      cio_data_t  d;
      logic [9:0] rnd;
      repeat (8)
      begin
         @(negedge s_6mhz);
         sw1 = $random(seed);
         sw2 = $random(seed);
         rnd = $random(seed);
         bus_read(make_addr(CODE_SWITCH, {rnd[9:1], 1'b0}), d);
         compare_data("rdata_o sw1", d, sw1);
         bus_read(make_addr(CODE_SWITCH, {rnd[9:1], 1'b1}), d);
         compare_data("rdata_o sw2", d, sw2);
      end
      // out0 and steering clear are write-only and read zero too
      for (int code = 0; code < 16; code++)
      begin
         if (code != CODE_SWITCH && code != CODE_INPUT)
         begin
            rnd = $random(seed);
            bus_read(make_addr(4'(code), rnd), d);
            compare_data($sformatf("rdata_o region %0d", code), d, 8'h00);
         end
      end
   endtask

   task automatic read_player_inputs();
      cio_data_t  d;
      logic [9:0] rnd;
      repeat (8)
      begin
         @(negedge s_6mhz);
         player   = $random(seed);
         joystick = $random(seed);
         vblank   = $random(seed);
         rnd      = $random(seed);
         bus_read(make_addr(CODE_INPUT, {rnd[9:2], 2'b00}), d);
         compare_data("rdata_o in0 low", d,
                      {exp_h_dir, vblank, player[6], player[5], exp_h_count});
         // coins, slam, fire, start
         bus_read(make_addr(CODE_INPUT, {rnd[9:2], 2'b01}), d);
         compare_data("rdata_o in0 high", d,
                      {player[9], player[8], player[7], player[4],
                       player[1], player[0], player[3], player[2]});
         bus_read(make_addr(CODE_INPUT, {rnd[9:2], 2'b11}), d);
         compare_data("rdata_o joystick", d, joystick);
         bus_read(make_addr(CODE_INPUT, {rnd[9:2], 2'b10}), d);
         compare_data("rdata_o in1 low", d, {exp_v_dir, 3'b000, exp_v_count});
      end
   endtask

   task automatic exercise_output_latch();
      logic [2:0] sel;
      cio_data_t  data;
      logic [9:0] rnd;
      repeat (24)
      begin
         rnd  = $random(seed);
         sel  = $random(seed);
         data = $random(seed);
         bus_write(make_addr(CODE_OUT0, {rnd[9:3], sel}), data);
         exp_latch[sel] = data[7];
         check_latch_outputs();
      end
   endtask

   task automatic run_trackball_counts();
      int         n_up;
      int         n_down;
      int         n_p1;
      logic [9:0] rnd;
      // flip low gives the axes to player 2
      rnd = $random(seed);
      bus_write(make_addr(CODE_OUT0, {rnd[9:3], 3'd7}), 8'h00);
      exp_latch[7] = 1'b0;
      compare_bit("flip_o", flip, 1'b0);
      n_up   = ($random(seed) & 7) + 1;
      n_down = ($random(seed) & 15) + 1;
      repeat (n_up) pulse_trackball(1'b0, 1'b1, 1'b1);
      // both directions must now read up
      check_trackball();
      repeat (n_down) pulse_trackball(1'b0, 1'b0, 1'b0);
      check_trackball();
      // flip high, player 2 pulses must be ignored now
      bus_write(make_addr(CODE_OUT0, {rnd[9:3], 3'd7}), 8'h80);
      exp_latch[7] = 1'b1;
      compare_bit("flip_o", flip, 1'b1);
      repeat (4) pulse_trackball(1'b0, 1'b1, 1'b0);
      check_trackball();
      n_p1 = ($random(seed) & 7) + 1;
      repeat (n_p1) pulse_trackball(1'b1, $random(seed), $random(seed));
      check_trackball();
   endtask

   task automatic steer_clear_write();
      logic [9:0] rnd;
      // move both counts off zero first
      while (exp_h_count == 4'd0 || exp_v_count == 4'd0)
         pulse_trackball(exp_latch[7], 1'b1, 1'b1);
      check_trackball();
      rnd = $random(seed);
      bus_write(make_addr(CODE_STEERCLR, rnd), $random(seed));
      exp_h_count = 4'd0;
      exp_v_count = 4'd0;
      check_trackball();
   endtask

   initial
   begin
      seed        = 46031;
      reset       = 1'b1;
      addr        = '0;
      wdata       = '0;
      rd          = 1'b0;
      wr          = 1'b0;
      sw1         = '0;
      sw2         = '0;
      player      = '0;
      joystick    = '0;
      trakball    = '0;
      vblank      = 1'b0;
      exp_latch   = '0;
      exp_h_count = '0;
      exp_v_count = '0;
      exp_h_dir   = 1'b0;
      exp_v_dir   = 1'b0;
      repeat (8) @(posedge s_6mhz);
      @(negedge s_6mhz);
      reset = 1'b0;
      @(negedge s_6mhz);
      verify_reset_state();
      sweep_switches_and_unmapped();
      read_player_inputs();
      exercise_output_latch();
      run_trackball_counts();
      steer_clear_write();
      $display("Testbench passed");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+common
common/centipede_io_pkg.sv
logic/io_addr_decoder.sv
logic/input_read_mux.sv
logic/output_latch.sv
trackball/trackball_axis.sv
logic/centipede_io_top.sv
sim/tb_centipede_io.sv

// ==== Bender.yml ====
package:
  name: centipede_io

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/centipede_io_pkg.sv
      - logic/io_addr_decoder.sv
      - logic/input_read_mux.sv
      - logic/output_latch.sv
      - trackball/trackball_axis.sv
      - logic/centipede_io_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_centipede_io.sv
